//--- geometry_processor.f
hdl/geo_cmd_pkg.sv
hdl/geo_pixel_pkg.sv
hdl/geo_pixel_if.sv
hdl/geometry_xy_plotter.sv
hdl/pixel_address_generator.sv
hdl/geo_pixel_writer.sv
hdl/geometry_processor.sv
tests/geometry_processor_sva.sv
tests/geometry_processor_tb.sv

//--- tests/geometry_processor_tb.sv
`timescale 1ns/1ps

module geometry_processor_tb;
   import geo_cmd_pkg::*;
   import geo_pixel_pkg::*;

   localparam int     N_CMDS      = 300;
   localparam int     RAM_WORDS   = SCREEN_H * WORDS_PER_LINE;  // 32000 words
   localparam longint WATCHDOG_NS = longint'(N_CMDS) * 20 * 40 * 8;
   localparam int     XOR_WORD    = 33 * 160 + 17 / 2;           // directed pixel (17, 33)

   logic        clk = 1'b0;
   logic        arst_n;
   logic        fifo_cmd_ready;
   logic [15:0] fifo_cmd_in;
   logic        fifo_cmd_busy;
   logic        rd_req, rd_data_rdy, ram_busy, wr_ena;
   logic [15:0] rd_data, ram_wr_data;
   logic [19:0] ram_addr;
   logic        collision_rst;
   logic [7:0]  collision_cnt;

   logic [15:0] ram [RAM_WORDS];      // pixel ram seen by the DUT
   logic [15:0] frame [RAM_WORDS];    // reference frame
   logic [11:0] m_x, m_y, m_x1;       // model pen registers
   logic [7:0]  m_colour;
   logic [3:0]  m_mode;
   int          exp_coll;             // saturating at 255
   int          seed = 72;
   int          rd_delay;
   int          err_img, err_coll, err_xor, err_fifo, total;
   logic [15:0] xor_word;
   logic        ram_hold;             // keeps ram_busy high to stall the writer
   bit          busy_ok;

   geometry_processor i_dut (.*);

   always #4 clk = ~clk;

   function automatic int rnd(input int n);  // 0 .. n-1
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   // clip one pixel of the frame model and merge it
   function automatic void model_pixel(input int px);
      int         a;
      logic [7:0] old_b;
      logic [7:0] new_b;
      if (px >= SCREEN_W || m_y >= SCREEN_H) return;
      a     = m_y * 160 + px / 2;
      old_b = px[0] ? frame[a][15:8] : frame[a][7:0];   // odd x is the high byte
      new_b = (m_mode == 4'd1) ? old_b ^ m_colour : m_colour;
      if (old_b != 8'h00 && exp_coll < 255) exp_coll++;
      if (px[0]) frame[a][15:8] = new_b;
      else frame[a][7:0] = new_b;
   endfunction

   function automatic void model_cmd(input logic [15:0] w);
      int xi;
      case (w[15:12])
         SET_PAINT: begin
            m_mode   = w[11:8];
            m_colour = w[7:0];
         end
         SET_X:  m_x  = w[11:0];
         SET_Y:  m_y  = w[11:0];
         SET_X1: m_x1 = w[11:0];
         PLOT:   model_pixel(m_x);
         HLINE: begin
            xi = m_x;
            model_pixel(xi);
            while (xi != m_x1) begin                     // walk toward x1 in either direction
               xi = (xi < m_x1) ? xi + 1 : xi - 1;
               model_pixel(xi);
            end
            m_x = m_x1;                                  // pen left at span end
         end
         default: ;
      endcase
   endfunction

   function automatic logic [15:0] rand_cmd();
      int k;
      int v;
      k = rnd(10);
      case (k)
         0: return {4'(7 + rnd(10)), 12'(rnd(4096))};   // 16 wraps to nop and 7..15 are undefined
         1: return {SET_PAINT, 4'(rnd(2) ? 1 : rnd(16)), 8'(rnd(256))};
         2: return {SET_X, 12'(rnd(340))};              // a few off the right edge
         3: return {SET_Y, 12'(rnd(210))};
         4: begin
            v = m_x + rnd(31) - 15;
            return {SET_X1, 12'(v < 0 ? 0 : v)};
         end
         5, 6: return {PLOT, 12'h000};
         default: return {HLINE, 12'h000};
      endcase
   endfunction

   // called and returns on a falling edge
   task automatic send_cmd(input logic [15:0] w);
      while (fifo_cmd_busy) @(negedge clk);
      fifo_cmd_ready = 1'b1;
      fifo_cmd_in    = w;
      model_cmd(w);
      @(negedge clk);
      fifo_cmd_ready = 1'b0;
   endtask

   // fifo empty and no ram traffic for 50 cycles
   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 50) begin
         @(posedge clk);
         if (rd_req || wr_ena || i_dut.i_plotter.fifo_cnt != 0) quiet = 0;
         else quiet++;
      end
      @(negedge clk);
   endtask

   // gives up after max_cycles falling edges
   task automatic wait_busy_low(input int max_cycles, output bit dropped);
      int n;
      n = 0;
      while (fifo_cmd_busy && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      dropped = !fifo_cmd_busy;
   endtask

   task automatic check_frame();
      for (int a = 0; a < RAM_WORDS; a++) begin
         assert (ram[a] === frame[a]) else begin
            if (err_img < 10)
               $display("ERROR %0t: word %0d is %h, expected %h", $time, a, ram[a], frame[a]);
            err_img++;
         end
      end
      assert (collision_cnt == exp_coll) else begin
         $display("ERROR %0t: collision_cnt %0d, expected %0d", $time, collision_cnt, exp_coll);
         err_coll++;
      end
   endtask

   // ram responder with 1 to 4 cycles of read latency and busy about a quarter of the time
   always @(negedge clk) begin
      rd_data_rdy <= 1'b0;
      ram_busy    <= ram_hold || (rnd(4) == 0);
      if (rd_req && !rd_data_rdy) begin
         if (rd_delay == 0) begin
            rd_data_rdy <= 1'b1;
            rd_data     <= ram[ram_addr];
         end else begin
            rd_delay <= rd_delay - 1;
         end
      end else if (!rd_req) begin
         rd_delay <= rnd(4);
      end
   end

   always @(posedge clk) begin
      if (wr_ena) begin
         assert (ram_addr < RAM_WORDS) else begin
            $display("ERROR %0t: write outside the frame at word %0d", $time, ram_addr);
            err_img++;
         end
         if (ram_addr < RAM_WORDS) ram[ram_addr] <= ram_wr_data;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: the DUT stopped making progress, run aborted at %0t", $time);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      fifo_cmd_ready = 1'b0;
      fifo_cmd_in    = '0;
      rd_data_rdy    = 1'b0;
      rd_data        = '0;
      ram_busy       = 1'b0;
      collision_rst  = 1'b0;
      ram_hold       = 1'b0;
      arst_n         = 1'b0;
      {m_x, m_y, m_x1, m_colour, m_mode} = '0;    // same as DUT reset values
      exp_coll = 0;
      err_img  = 0;
      err_coll = 0;
      err_xor  = 0;
      err_fifo = 0;
      for (int a = 0; a < RAM_WORDS; a++) begin
         ram[a][7:0]  = rnd(2) ? 8'(rnd(256)) : 8'h00;   // about half the pixels blank
         ram[a][15:8] = rnd(2) ? 8'(rnd(256)) : 8'h00;
         frame[a]     = ram[a];
      end
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // double xor on one pixel and then spans across the right edge both ways
      xor_word = frame[XOR_WORD];
      send_cmd({SET_PAINT, 4'd1, 8'h5a});
      send_cmd({SET_X, 12'd17});
      send_cmd({SET_Y, 12'd33});
      send_cmd({PLOT, 12'd0});
      wait_idle();
      assert (ram[XOR_WORD] === frame[XOR_WORD]) else begin
         $display("ERROR %0t: single xor left %h, expected %h", $time, ram[XOR_WORD],
                  frame[XOR_WORD]);
         err_xor++;
      end
      send_cmd({PLOT, 12'd0});
      wait_idle();
      assert (ram[XOR_WORD] === xor_word) else begin
         $display("ERROR %0t: double xor left %h, expected %h", $time, ram[XOR_WORD], xor_word);
         err_xor++;
      end
      send_cmd({SET_PAINT, 4'd0, 8'hc3});
      send_cmd({SET_X, 12'd300});
      send_cmd({SET_X1, 12'd330});
      send_cmd({HLINE, 12'd0});
      send_cmd({SET_X1, 12'd290});                  // next span runs right to left
      send_cmd({HLINE, 12'd0});
      wait_idle();

      // writer, address stage and plotter each hold one plot, nops pile up behind
      ram_hold = 1'b1;
      repeat (3) send_cmd({PLOT, 12'd0});
      repeat (11) send_cmd({NOP, 12'd0});
      wait_busy_low(100, busy_ok);
      assert (busy_ok) else begin
         $display("ERROR %0t: fifo_cmd_busy still high with 11 commands queued", $time);
         err_fifo++;
      end
      send_cmd({NOP, 12'd0});                       // 12 queued leaves 4 free
      assert (fifo_cmd_busy) else begin
         $display("ERROR %0t: fifo_cmd_busy low with 12 commands queued", $time);
         err_fifo++;
      end
      ram_hold = 1'b0;

      for (int i = 0; i < N_CMDS / 2; i++)
         send_cmd(rand_cmd());
      wait_idle();
      check_frame();

      collision_rst = 1'b1;
      @(negedge clk);
      collision_rst = 1'b0;
      exp_coll      = 0;
      assert (collision_cnt == 0) else begin
         $display("ERROR %0t: collision_cnt %0d after clear", $time, collision_cnt);
         err_coll++;
      end
      for (int i = 0; i < N_CMDS / 2; i++)
         send_cmd(rand_cmd());
      wait_idle();
      check_frame();

      total = err_img + err_coll + err_xor + err_fifo + i_dut.i_sva.fail_cnt;
      $display("errors: frame %0d, collision %0d, xor %0d, fifo %0d, protocol %0d",
               err_img, err_coll, err_xor, err_fifo, i_dut.i_sva.fail_cnt);
      if (total == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- tests/geometry_processor_sva.sv
`timescale 1ns/1ps

module geometry_processor_sva (
   input logic clk,
   input logic arst_n,
   input logic fifo_cmd_ready,
   input logic fifo_cmd_busy,
   input logic rd_req,
   input logic rd_data_rdy,
   input logic ram_busy,
   input logic wr_ena
);
   int fail_cnt = 0;   // failures so far, read by the testbench

   a_wr_free: assert property (@(posedge clk) disable iff (!arst_n) wr_ena |-> !ram_busy)
      else begin
         $error("wr_ena while ram_busy");
         fail_cnt++;
      end

   // read request held until the data strobe, released right after it
   a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
                               rd_req && !rd_data_rdy |=> rd_req)
      else begin
         $error("rd_req dropped before rd_data_rdy");
         fail_cnt++;
      end

   a_rd_drop: assert property (@(posedge clk) disable iff (!arst_n)
                               rd_req && rd_data_rdy |=> !rd_req)
      else begin
         $error("rd_req still high after rd_data_rdy");
         fail_cnt++;
      end

   // margin allows one strobe in the cycle busy rises
   a_host: assert property (@(posedge clk) disable iff (!arst_n)
                            fifo_cmd_ready |-> !fifo_cmd_busy || !$past(fifo_cmd_busy))
      else begin
         $error("command strobe while fifo busy");
         fail_cnt++;
      end

   a_rd_wr: assert property (@(posedge clk) disable iff (!arst_n) !(rd_req && wr_ena))
      else begin
         $error("rd_req and wr_ena high together");
         fail_cnt++;
      end

endmodule

bind geometry_processor geometry_processor_sva i_sva (.*);

//--- hdl/geometry_processor.sv
`timescale 1ns/1ps

module geometry_processor (
   input  logic                                clk,
   input  logic                                arst_n,
   // host command port
   input  logic                                fifo_cmd_ready,
   input  logic [15:0]                         fifo_cmd_in,
   output logic                                fifo_cmd_busy,
   // pixel ram port
   output logic                                rd_req,
   input  logic                                rd_data_rdy,
   input  logic [geo_pixel_pkg::RAM_DATA_W-1:0] rd_data,
   input  logic                                ram_busy,
   output logic                                wr_ena,
   output logic [geo_pixel_pkg::RAM_ADDR_W-1:0] ram_addr,
   output logic [geo_pixel_pkg::RAM_DATA_W-1:0] ram_wr_data,
   // collision counter
   input  logic                                collision_rst,
   output logic [7:0]                          collision_cnt
);

   geo_pixel_if plot_to_addr ();   // x, y, colour, mode
   geo_pixel_if addr_to_wr ();     // plus word address and lane

   geometry_xy_plotter i_plotter (
      .clk            (clk),
      .arst_n         (arst_n),
      .fifo_cmd_ready (fifo_cmd_ready),
      .fifo_cmd_in    (fifo_cmd_in),
      .fifo_cmd_busy  (fifo_cmd_busy),
      .pix            (plot_to_addr.src)
   );

   pixel_address_generator i_addr_gen (
      .clk     (clk),
      .arst_n  (arst_n),
      .pix_in  (plot_to_addr.dst),
      .pix_out (addr_to_wr.src)
   );

   geo_pixel_writer i_writer (
      .clk           (clk),
      .arst_n        (arst_n),
      .pix           (addr_to_wr.dst),
      .rd_req        (rd_req),
      .rd_data_rdy   (rd_data_rdy),
      .rd_data       (rd_data),
      .ram_busy      (ram_busy),
      .wr_ena        (wr_ena),
      .ram_addr      (ram_addr),
      .ram_wr_data   (ram_wr_data),
      .collision_rst (collision_rst),
      .collision_cnt (collision_cnt)
   );

endmodule

//--- hdl/geo_pixel_writer.sv
`timescale 1ns/1ps

module geo_pixel_writer (
   input  logic                                clk,
   input  logic                                arst_n,
   geo_pixel_if.dst                            pix,
   output logic                                rd_req,       // held until rd_data_rdy
   input  logic                                rd_data_rdy,
   input  logic [geo_pixel_pkg::RAM_DATA_W-1:0] rd_data,
   input  logic                                ram_busy,
   output logic                                wr_ena,       // single-cycle write strobe
   output logic [geo_pixel_pkg::RAM_ADDR_W-1:0] ram_addr,
   output logic [geo_pixel_pkg::RAM_DATA_W-1:0] ram_wr_data,
   input  logic                                collision_rst,
   output logic [7:0]                          collision_cnt
);
   import geo_pixel_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_ACK, S_READ, S_WRITE, S_REL} wr_state_e;

   wr_state_e             state;
   logic                  lane_r;
   logic [PIXEL_W-1:0]    colour_r;
   draw_mode_e            mode_r;
   logic                  old_nz;     // target pixel was already painted
   logic [PIXEL_W-1:0]    old_byte;
   logic [PIXEL_W-1:0]    new_byte;
   logic [RAM_DATA_W-1:0] merged;

   // lane select and mode merge on the word coming back from ram
   always_comb begin
      old_byte = lane_r ? rd_data[15:8] : rd_data[7:0];
      if (mode_r == MODE_XOR)
         new_byte = old_byte ^ colour_r;
      else
         new_byte = colour_r;            // set and undefined modes
      merged = lane_r ? {new_byte, rd_data[7:0]} : {rd_data[15:8], new_byte};
   end

   // write only goes out in a cycle the ram is free
   assign wr_ena = (state == S_WRITE) && !ram_busy;

   // pixel payload, loaded on capture and on read return
   always_ff @(posedge clk) begin
      if (state == S_IDLE && pix.req && !pix.ack) begin
         ram_addr <= pix.word_addr;
         lane_r   <= pix.lane;
         colour_r <= pix.colour;
         mode_r   <= pix.mode;
      end
      if (state == S_READ && rd_data_rdy) begin
         ram_wr_data <= merged;
         old_nz      <= (old_byte != '0);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= S_IDLE;
         pix.ack <= 1'b0;
         rd_req  <= 1'b0;
      end else begin
         if (pix.ack && !pix.req) pix.ack <= 1'b0;  // close the handshake
         case (state)
            S_IDLE: if (pix.req && !pix.ack) state <= S_ACK;
            S_ACK: begin
               pix.ack <= 1'b1;                      // one cycle after capture
               rd_req  <= 1'b1;
               state   <= S_READ;
            end
            S_READ: if (rd_data_rdy) begin
               rd_req <= 1'b0;
               state  <= S_WRITE;
            end
            S_WRITE: if (!ram_busy) state <= S_REL;
            S_REL:   if (!pix.ack) state <= S_IDLE;  // wait for req/ack low
            default: state <= S_IDLE;
         endcase
      end
   end

   // saturating count of writes onto non-zero pixels
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         collision_cnt <= '0;
      else if (collision_rst)
         collision_cnt <= '0;
      else if (wr_ena && old_nz && collision_cnt != 8'hff)
         collision_cnt <= collision_cnt + 1'b1;
   end

endmodule

//--- hdl/pixel_address_generator.sv
`timescale 1ns/1ps

module pixel_address_generator (
   input  logic     clk,
   input  logic     arst_n,
   geo_pixel_if.dst pix_in,
   geo_pixel_if.src pix_out
);
   import geo_pixel_pkg::*;

   logic                  take;      // capture the incoming pixel
   logic                  out_wait;  // out req dropped, ack still high
   logic [RAM_ADDR_W-1:0] y_ext;
   logic [RAM_ADDR_W-1:0] addr_calc;

   // y * 160 + x / 2
   assign y_ext     = RAM_ADDR_W'(pix_in.y);
   assign addr_calc = (y_ext << LINE_SHIFT_HI) + (y_ext << LINE_SHIFT_LO)
                    + RAM_ADDR_W'(pix_in.x >> 1);

   // one op at a time, both handshakes must be closed
   assign take = pix_in.req && !pix_in.ack && !pix_out.req && !out_wait;

   always_ff @(posedge clk) begin
      if (take) begin
         pix_out.x         <= pix_in.x;
         pix_out.y         <= pix_in.y;
         pix_out.colour    <= pix_in.colour;
         pix_out.mode      <= pix_in.mode;
         pix_out.word_addr <= addr_calc;
         pix_out.lane      <= pix_in.x[0];  // odd x in high byte
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pix_in.ack  <= 1'b0;
         pix_out.req <= 1'b0;
         out_wait    <= 1'b0;
      end else begin
         if (take) begin
            pix_in.ack  <= 1'b1;               // ack and forward in one go
            pix_out.req <= 1'b1;
         end else if (pix_in.ack && !pix_in.req) begin
            pix_in.ack  <= 1'b0;
         end
         if (pix_out.req && pix_out.ack) begin
            pix_out.req <= 1'b0;
            out_wait    <= 1'b1;
         end else if (out_wait && !pix_out.ack) begin
            out_wait    <= 1'b0;
         end
      end
   end

endmodule

//--- hdl/geometry_xy_plotter.sv
`timescale 1ns/1ps

module geometry_xy_plotter (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 fifo_cmd_ready,  // one-cycle write strobe
   input  geo_cmd_pkg::geo_cmd_u fifo_cmd_in,
   output logic                 fifo_cmd_busy,   // early full flag
   geo_pixel_if.src             pix
);
   import geo_cmd_pkg::*;
   import geo_pixel_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_PIX, S_REQ, S_REL} plot_state_e;

   geo_cmd_u               fifo_mem [CMD_FIFO_DEPTH];
   logic [CMD_FIFO_AW-1:0] wr_ptr, rd_ptr;
   logic [CMD_FIFO_AW:0]   fifo_cnt;
   logic                   push, pop;
   geo_cmd_u               head;

   plot_state_e            state;
   logic [COORD_W-1:0]     x_reg, y_reg, x1_reg;
   logic [COORD_W-1:0]     cur_x;              // pixel being drawn
   logic [PIXEL_W-1:0]     colour_reg;
   draw_mode_e             mode_reg;
   logic                   span;               // hline in progress
   logic                   last_pix;
   logic                   on_screen;
   logic [COORD_W-1:0]     next_x;

   // command fifo
   assign push = fifo_cmd_ready && (fifo_cnt != (CMD_FIFO_AW+1)'(CMD_FIFO_DEPTH));
   assign pop  = (state == S_IDLE) && (fifo_cnt != '0);  // only when engine is idle
   assign head = fifo_mem[rd_ptr];
   assign fifo_cmd_busy = fifo_cnt >= (CMD_FIFO_AW+1)'(CMD_FIFO_DEPTH - CMD_FIFO_MARGIN);

   always_ff @(posedge clk) begin
      if (push) fifo_mem[wr_ptr] <= fifo_cmd_in;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         fifo_cnt <= fifo_cnt + push - pop;
      end
   end

   // span stepping, either direction toward x1
   assign last_pix  = !span || (cur_x == x1_reg);
   assign next_x    = (cur_x < x1_reg) ? cur_x + 1'b1 : cur_x - 1'b1;
   assign on_screen = (cur_x < COORD_W'(SCREEN_W)) && (y_reg < COORD_W'(SCREEN_H));

   // payload stays put while req is up
   assign pix.x      = cur_x;
   assign pix.y      = y_reg;
   assign pix.colour = colour_reg;
   assign pix.mode   = mode_reg;
   // word_addr and lane are left to the address stage

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= S_IDLE;
         pix.req    <= 1'b0;
         x_reg      <= '0;
         y_reg      <= '0;
         x1_reg     <= '0;
         cur_x      <= '0;
         colour_reg <= '0;
         mode_reg   <= MODE_SET;
         span       <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (pop) begin
               case (head.coord.opcode)
                  SET_PAINT: begin
                     colour_reg <= head.paint.colour;
                     mode_reg   <= draw_mode_e'(head.paint.mode);
                  end
                  SET_X:  x_reg  <= head.coord.value;
                  SET_Y:  y_reg  <= head.coord.value;
                  SET_X1: x1_reg <= head.coord.value;
                  PLOT: begin
                     cur_x <= x_reg;
                     span  <= 1'b0;
                     state <= S_PIX;
                  end
                  HLINE: begin
                     cur_x <= x_reg;
                     x_reg <= x1_reg;  // pen ends at the span end
                     span  <= 1'b1;
                     state <= S_PIX;
                  end
                  default: ;           // nop and unknown opcodes
               endcase
            end
            S_PIX: begin
               if (on_screen) begin
                  pix.req <= 1'b1;
                  state   <= S_REQ;
               end else if (last_pix) begin
                  state   <= S_IDLE;   // clipped, nothing sent
               end else begin
                  cur_x   <= next_x;
               end
            end
            S_REQ: if (pix.ack) begin
               pix.req <= 1'b0;
               state   <= S_REL;
            end
            S_REL: if (!pix.ack) begin  // handshake fully closed
               if (last_pix) begin
                  state <= S_IDLE;
               end else begin
                  cur_x <= next_x;
                  state <= S_PIX;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- hdl/geo_pixel_if.sv
`timescale 1ns/1ps

interface geo_pixel_if;
   import geo_pixel_pkg::*;

   logic                  req;        // four-phase request
   logic                  ack;        // four-phase acknowledge
   logic [COORD_W-1:0]    x;
   logic [COORD_W-1:0]    y;
   logic [PIXEL_W-1:0]    colour;
   draw_mode_e            mode;
   logic [RAM_ADDR_W-1:0] word_addr;  // only valid after address stage
   logic                  lane;       // 1 = high byte

   modport src (output req, x, y, colour, mode, word_addr, lane, input ack);
   modport dst (input req, x, y, colour, mode, word_addr, lane, output ack);

endinterface

//--- hdl/geo_pixel_pkg.sv
package geo_pixel_pkg;

   localparam int COORD_W        = 12;
   localparam int SCREEN_W       = 320;
   localparam int SCREEN_H       = 200;
   localparam int WORDS_PER_LINE = 160;   // two pixels per ram word

   localparam int RAM_ADDR_W = 20;
   localparam int RAM_DATA_W = 16;
   localparam int PIXEL_W    = 8;

   // row stride 160 = 128 + 32, built from two shifts
   localparam int LINE_SHIFT_HI = 7;
   localparam int LINE_SHIFT_LO = 5;

   // anything not listed paints like MODE_SET
   typedef enum logic [3:0] {
      MODE_SET = 4'd0,
      MODE_XOR = 4'd1
   } draw_mode_e;

endpackage

//--- hdl/geo_cmd_pkg.sv
package geo_cmd_pkg;

   // host command opcodes, always in the top nibble of the word
   typedef enum logic [3:0] {
      NOP       = 4'h0,
      SET_PAINT = 4'h1,        // colour and draw mode
      SET_X     = 4'h2,
      SET_Y     = 4'h3,
      SET_X1    = 4'h4,        // span end
      PLOT      = 4'h5,        // single pixel at (x, y)
      HLINE     = 4'h6         // span from x to x1 on row y
   } geo_opcode_e;

   typedef struct packed {
      geo_opcode_e opcode;
      logic [11:0] value;      // x, y or x1
   } geo_coord_cmd_t;

   typedef struct packed {
      geo_opcode_e opcode;
      logic [3:0]  mode;       // raw draw mode bits
      logic [7:0]  colour;
   } geo_paint_cmd_t;

   // same 16-bit word, two decodings picked by opcode
   typedef union packed {
      geo_coord_cmd_t coord;
      geo_paint_cmd_t paint;
   } geo_cmd_u;

   localparam int CMD_FIFO_DEPTH  = 16;
   localparam int CMD_FIFO_AW     = $clog2(CMD_FIFO_DEPTH);
   localparam int CMD_FIFO_MARGIN = 4;  // free entries left when busy rises
endpackage
